/* tb/walksat_cases.txt */
# W <var hex> <value> : variable table write
# C <name> <lit0> <lit1> <lit2> <1 unsat, 0 sat> : literal hex is {neg, var[5:0]}
# S 1 holds flip_ready_i low then random stalls, S 0 returns to always ready
W 01 1
W 02 1
W 0a 1
W 14 1
W 3f 1
W 05 1
C u_first 03 41 04 1
C s_pos 01 03 04 0
C u_neg 41 42 4a 1
C s_neg 43 41 42 0
C s_w5 05 00 00 0
W 05 0
C u_w5 05 00 00 1
C s_run0 01 00 00 0
C s_run1 00 02 00 0
C s_run2 00 00 0a 0
C s_run3 14 41 00 0
C s_run4 7f 3f 03 0
C s_run5 06 46 00 0
S 1
C u_st0 00 41 03 1
C u_st1 04 42 06 1
C u_st2 07 4a 11 1
C u_st3 30 54 3e 1
C u_st4 41 42 7f 1
C u_st5 00 00 00 1
C u_st6 41 41 41 1
C u_st7 03 7f 3e 1
C u_st8 11 7f 04 1
C u_st9 06 54 30 1
C s_st0 0a 00 00 0
C u_st10 4a 07 54 1
S 0
C u_end 7f 04 41 1
C s_end 42 3f 00 0

/* walksat_flip_core.f */
+incdir+hdl
hdl/sat_pkg.sv
hdl/clause_checker.sv
hdl/unsat_clause_fifo.sv
hdl/flip_selector.sv
hdl/walksat_flip_core.sv
tb/tb_walksat_flip_core.sv

/* Makefile */
# Verilator build and run of the WalkSAT flip core testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_walksat_flip_core \
		-f walksat_flip_core.f --Mdir obj_dir -o sim_walksat

run: compile
	./obj_dir/sim_walksat | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_walksat_flip_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the WalkSAT flip core
// reads tb/walksat_cases.txt relative to the project root
// flip_ready_i stalls are random with a fixed seed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "sat_cfg.svh"

module tb_walksat_flip_core
    import sat_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;

    logic       clk_i;
    logic       rst_i;
    var_write_t var_wr_i;
    clause_t    clause_i;
    logic       clause_valid_i;
    logic       clause_ready_o;
    flip_t      flip_o;
    logic       flip_valid_o;
    logic       flip_ready_i;

    // unsatisfied clauses in acceptance order
    clause_t         exp_clause_q[$];
    logic [8*24-1:0] exp_name_q[$];
    logic [31:0]     prng_model;
    int              pass_count;
    int              fail_count;
    bit              timed_out;
    // ready mode 0 means always ready, 1 random stretches and 2 held low
    int              ready_mode;
    int              stretch_left;
    bit              hold_active;
    int              hold_unsat;
    bit              prev_stalled;
    flip_t           prev_flip;

    walksat_flip_core i_walksat_flip_core (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .var_wr_i       (var_wr_i),
        .clause_i       (clause_i),
        .clause_valid_i (clause_valid_i),
        .clause_ready_o (clause_ready_o),
        .flip_o         (flip_o),
        .flip_valid_o   (flip_valid_o),
        .flip_ready_i   (flip_ready_i)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    // ready moves a little after the clause inputs
    initial begin : ready_driver
        void'($urandom(32'h62b676ac));
        forever begin
            @(posedge clk_i);
            #2;
            if (ready_mode == 1) begin
                if (stretch_left == 0) begin
                    flip_ready_i = ($urandom % 2) != 0;
                    stretch_left = 1 + int'($urandom % 6);
                end else begin
                    stretch_left = stretch_left - 1;
                end
            end else begin
                flip_ready_i = (ready_mode == 0);
            end
        end
    end

    // a flip seen valid and ready at the falling edge is taken at the next rising edge
    always @(negedge clk_i) begin : flip_monitor
        clause_t         c;
        logic [8*24-1:0] nm;
        flip_t           exp_f;
        if (prev_stalled && !(flip_valid_o && flip_o === prev_flip)) begin
            $display("[ERROR] stall_hold: expected %h, actual %h", prev_flip, flip_o);
            fail_count++;
        end
        if (flip_valid_o && flip_ready_i && exp_clause_q.size() == 0) begin
            $display("unexpected flip on flip_o with no unsatisfied clause pending");
            fail_count++;
        end else if (flip_valid_o && flip_ready_i) begin
            c  = exp_clause_q.pop_front();
            nm = exp_name_q.pop_front();
            prng_model   = xorshift_step(prng_model);
            exp_f.idx    = SAT_IDX_W'(prng_model % 32'd3);
            exp_f.addr   = c[exp_f.idx].addr;
            exp_f.clause = c;
            if (flip_o !== exp_f) begin
                $display("[ERROR] %0s: expected %h, actual %h", nm, exp_f, flip_o);
                fail_count++;
            end else begin
                $display("PASS %0s: literal %0d, variable %0d", nm, exp_f.idx, exp_f.addr);
                pass_count++;
            end
        end
        prev_stalled = flip_valid_o && !flip_ready_i;
        prev_flip    = flip_o;
    end

    task automatic write_var(input int addr, input int val);
        var_wr_i.en    = 1'b1;
        var_wr_i.addr  = `SAT_VAR_ADDR_W'(addr);
        var_wr_i.value = val[0];
        @(posedge clk_i);
        #1;
        var_wr_i = '0;
    endtask

    task automatic end_hold();
        if (hold_unsat > `SAT_FIFO_DEPTH + 1) begin
            $display("[ERROR] stall_fill: expected %0d, actual %0d",
                     `SAT_FIFO_DEPTH + 1, hold_unsat);
            fail_count++;
        end else begin
            $display("PASS stall_fill: clause_ready_o fell after %0d clauses", hold_unsat);
            pass_count++;
        end
        hold_active = 1'b0;
        ready_mode  = 1;
    endtask

    task automatic run_clause(input logic [8*24-1:0] name, input clause_t c, input bit unsat);
        int waited;
        bit seen_low;
        bit check_ready;
        // credits must be there with no backlog and no stall
        check_ready    = (ready_mode == 0) && (exp_clause_q.size() == 0) && !unsat;
        clause_i       = c;
        clause_valid_i = 1'b1;
        waited         = 0;
        seen_low       = 1'b0;
        @(negedge clk_i);
        while (!clause_ready_o && waited < WAIT_LIMIT) begin
            seen_low = 1'b1;
            if (hold_active) begin
                end_hold();
            end
            @(negedge clk_i);
            waited++;
        end
        if (!clause_ready_o) begin
            $display("timeout waiting for clause_ready_o on %0s", name);
            timed_out = 1'b1;
        end else begin
            @(posedge clk_i);
            #1;
            clause_valid_i = 1'b0;
            if (unsat) begin
                exp_clause_q.push_back(c);
                exp_name_q.push_back(name);
                hold_unsat = hold_unsat + int'(hold_active);
            end else if (check_ready && seen_low) begin
                $display("[ERROR] %0s: expected clause_ready_o 1, actual 0", name);
                fail_count++;
            end else begin
                $display("PASS %0s: satisfied clause accepted", name);
                pass_count++;
            end
        end
    endtask

    initial begin : stimulus
        int              fd;
        int              code;
        int              waited;
        int              addr;
        int              val;
        string           line;
        logic [8*16-1:0] tok;
        logic [8*24-1:0] name;
        logic [6:0]      lit0;
        logic [6:0]      lit1;
        logic [6:0]      lit2;
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        var_wr_i       = '0;
        clause_i       = '0;
        clause_valid_i = 1'b0;
        flip_ready_i   = 1'b1;
        ready_mode     = 0;
        stretch_left   = 0;
        hold_active    = 1'b0;
        hold_unsat     = 0;
        prev_stalled   = 1'b0;
        prev_flip      = '0;
        pass_count     = 0;
        fail_count     = 0;
        timed_out      = 1'b0;
        prng_model     = `SAT_PRNG_SEED;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        if (flip_valid_o !== 1'b0 || clause_ready_o !== 1'b1) begin
            $display("[ERROR] reset_state: expected 01, actual %b%b",
                     flip_valid_o, clause_ready_o);
            fail_count++;
        end else begin
            $display("PASS reset_state: no flip, clause_ready_o high");
            pass_count++;
        end
        @(posedge clk_i);
        #1;
        fd = $fopen("tb/walksat_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/walksat_cases.txt");
            fail_count++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                code = $fgets(line, fd);
                tok  = '0;
                if (code > 0) begin
                    code = $sscanf(line, "%s", tok);
                end
                if (code > 0 && tok == "W") begin
                    code = $sscanf(line, "%s %h %h", tok, addr, val);
                    write_var(addr, val);
                end else if (code > 0 && tok == "C") begin
                    code = $sscanf(line, "%s %s %h %h %h %d", tok, name, lit0, lit1, lit2, val);
                    if (code != 6) begin
                        $display("malformed clause line in cases file: %s", line);
                        fail_count++;
                    end
                    run_clause(name, clause_t'({lit2, lit1, lit0}), val != 0);
                end else if (code > 0 && tok == "S") begin
                    code = $sscanf(line, "%s %d", tok, val);
                    if (val != 0) begin
                        hold_active = 1'b1;
                        hold_unsat  = 0;
                        ready_mode  = 2;
                    end else begin
                        if (hold_active) begin
                            $display("clause_ready_o never fell while flip_ready_i was low");
                            fail_count++;
                            hold_active = 1'b0;
                        end
                        ready_mode = 0;
                    end
                end
            end
            $fclose(fd);
        end
        ready_mode = 0;
        waited     = 0;
        while (!timed_out && exp_clause_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!timed_out && exp_clause_q.size() != 0) begin
            $display("timeout with %0d flips still missing", exp_clause_q.size());
            timed_out = 1'b1;
        end
        // nothing more may come out in a short quiet window
        repeat (4) @(negedge clk_i);
        if (!timed_out && flip_valid_o !== 1'b0) begin
            $display("[ERROR] drain: expected flip_valid_o 0, actual %b", flip_valid_o);
            fail_count++;
        end else if (!timed_out) begin
            $display("PASS drain: no extra flips");
            pass_count++;
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (!timed_out && fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/walksat_flip_core.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unsat clause search and flip pick, one evaluator
// flips are reported only, never written back
// unsat clause to flip_valid_o is 3 cycles when idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "sat_cfg.svh"

module walksat_flip_core
    import sat_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,
    input  var_write_t var_wr_i,
    input  clause_t    clause_i,
    input  wire        clause_valid_i,
    output logic       clause_ready_o,
    output flip_t      flip_o,
    output logic       flip_valid_o,
    input  wire        flip_ready_i
);

    // checker to buffer
    logic    chk_push;
    clause_t chk_push_clause;
    logic    ucf_credit;

    // buffer to selector
    clause_t ucf_head;
    logic    ucf_not_empty;
    logic    fs_pop;

    clause_checker i_clause_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .var_wr_i       (var_wr_i),
        .clause_i       (clause_i),
        .clause_valid_i (clause_valid_i),
        .clause_ready_o (clause_ready_o),
        .credit_i       (ucf_credit),
        .push_o         (chk_push),
        .push_clause_o  (chk_push_clause)
    );

    unsat_clause_fifo i_unsat_clause_fifo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .push_i        (chk_push),
        .push_clause_i (chk_push_clause),
        .pop_i         (fs_pop),
        .head_o        (ucf_head),
        .not_empty_o   (ucf_not_empty),
        .credit_o      (ucf_credit)
    );

    flip_selector i_flip_selector (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .head_i       (ucf_head),
        .not_empty_i  (ucf_not_empty),
        .pop_o        (fs_pop),
        .flip_o       (flip_o),
        .flip_valid_o (flip_valid_o),
        .flip_ready_i (flip_ready_i)
    );

endmodule

`default_nettype wire

/* hdl/flip_selector.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks one literal of each queued clause
// xorshift32 (13, 17, 5), advanced once per pop
// flip_o holds while valid and not ready
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "sat_cfg.svh"

module flip_selector
    import sat_pkg::*;
(
    input  wire     clk_i,
    input  wire     rst_i,
    input  clause_t head_i,
    input  wire     not_empty_i,
    output logic    pop_o,
    output flip_t   flip_o,
    output logic    flip_valid_o,
    input  wire     flip_ready_i
);

    logic [31:0]          prng_q;
    logic [31:0]          prng_nxt;
    logic [31:0]          prng_rem;
    logic [SAT_IDX_W-1:0] sel_idx;
    logic                 flip_vld_q;
    flip_t                flip_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign prng_nxt = xorshift32(prng_q);
    assign prng_rem = prng_nxt % 32'(`SAT_NSAT);
    assign sel_idx  = prng_rem[SAT_IDX_W-1:0];

    // take the head when the output slot is free or draining
    assign pop_o = not_empty_i && (!flip_vld_q || flip_ready_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prng_q     <= `SAT_PRNG_SEED;
            flip_vld_q <= 1'b0;
        end else begin
            if (pop_o) begin
                prng_q     <= prng_nxt;
                flip_vld_q <= 1'b1;
            end else if (flip_ready_i) begin
                flip_vld_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            flip_q.idx    <= sel_idx;
            flip_q.addr   <= head_i[sel_idx].addr;
            flip_q.clause <= head_i;
        end
    end

    assign flip_o       = flip_q;
    assign flip_valid_o = flip_vld_q;

endmodule

`default_nettype wire

/* hdl/unsat_clause_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order queue of unsatisfied clauses
// no full check, the producer's credits prevent it
// head is valid only while not_empty_o is high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "sat_cfg.svh"

module unsat_clause_fifo
    import sat_pkg::*;
(
    input  wire     clk_i,
    input  wire     rst_i,
    input  wire     push_i,
    input  clause_t push_clause_i,
    input  wire     pop_i,
    output clause_t head_o,
    output logic    not_empty_o,
    output logic    credit_o
);

    localparam int PTR_W = $clog2(`SAT_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`SAT_FIFO_DEPTH + 1);

    clause_t            mem [`SAT_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_pop;

    assign not_empty_o = (count_q != '0);
    assign do_pop      = pop_i && not_empty_o;
    assign head_o      = mem[rd_ptr_q];

    // one credit back per removed entry
    assign credit_o = do_pop;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_clause_i;
        end
    end

    // pointers wrap on their own at a power-of-two depth
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/clause_checker.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// evaluates clauses against the variable table
// a table write lands one cycle after it is given
// push_o never exceeds the credits handed back
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "sat_cfg.svh"

module clause_checker
    import sat_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,
    input  var_write_t var_wr_i,
    input  clause_t    clause_i,
    input  wire        clause_valid_i,
    output logic       clause_ready_o,
    input  wire        credit_i,
    output logic       push_o,
    output clause_t    push_clause_o
);

    localparam int CRED_W = $clog2(`SAT_FIFO_DEPTH + 1);

    logic [`SAT_NUM_VARS-1:0] var_tbl_q;
    logic [CRED_W-1:0]        credit_q;
    logic                     accept;
    logic [`SAT_NSAT-1:0]     lit_true;
    logic                     unsat;

    // evaluation stage
    logic    eval_vld_q;
    logic    eval_unsat_q;
    clause_t eval_clause_q;

    assign clause_ready_o = (credit_q != '0);
    assign accept         = clause_valid_i && clause_ready_o;

    // literal is true when value and negation bit differ
    always_comb begin
        for (int i = 0; i < `SAT_NSAT; i++) begin
            lit_true[i] = var_tbl_q[clause_i[i].addr] ^ clause_i[i].neg;
        end
        unsat = ~|lit_true;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            var_tbl_q <= '0;
        end else if (var_wr_i.en) begin
            var_tbl_q[var_wr_i.addr] <= var_wr_i.value;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            eval_vld_q   <= 1'b0;
            eval_unsat_q <= 1'b0;
        end else begin
            eval_vld_q   <= accept;
            eval_unsat_q <= unsat;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            eval_clause_q <= clause_i;
        end
    end

    // satisfied clauses give their credit straight back
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= CRED_W'(`SAT_FIFO_DEPTH);
        end else begin
            credit_q <= credit_q
                      + CRED_W'(eval_vld_q && !eval_unsat_q)
                      + CRED_W'(credit_i)
                      - CRED_W'(accept);
        end
    end

    assign push_o        = eval_vld_q && eval_unsat_q;
    assign push_clause_o = eval_clause_q;

endmodule

`default_nettype wire

/* hdl/sat_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the WalkSAT flip core
// widths follow sat_cfg.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "sat_cfg.svh"

package sat_pkg;

    // width of a literal index within one clause
    localparam int SAT_IDX_W = $clog2(`SAT_NSAT);

    // negation bit sits above the variable address
    typedef struct packed {
        logic                       neg;
        logic [`SAT_VAR_ADDR_W-1:0] addr;
    } literal_t;

    // literal 0 in the low bits
    typedef literal_t [`SAT_NSAT-1:0] clause_t;

    // host write into the variable table
    typedef struct packed {
        logic                       en;
        logic [`SAT_VAR_ADDR_W-1:0] addr;
        logic                       value;
    } var_write_t;

    // chosen flip with the clause it came from
    typedef struct packed {
        logic [SAT_IDX_W-1:0]       idx;
        logic [`SAT_VAR_ADDR_W-1:0] addr;
        clause_t                    clause;
    } flip_t;

endpackage

`default_nettype wire

/* hdl/sat_cfg.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing for the WalkSAT flip core
// SAT_NUM_VARS must equal 2**SAT_VAR_ADDR_W
// SAT_FIFO_DEPTH must be a power of two
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SAT_CFG_SVH
`define SAT_CFG_SVH

// literals per clause, 3-SAT
`define SAT_NSAT 3

// variable addressing
`define SAT_VAR_ADDR_W 6
`define SAT_NUM_VARS 64

// unsat clause buffer entries, also the checker's starting credits
`define SAT_FIFO_DEPTH 8

// xorshift state after reset, must be nonzero
`define SAT_PRNG_SEED 32'h2545f491

`endif
